//--- include/cdr_defs.svh
`ifndef CDR_DEFS_SVH
`define CDR_DEFS_SVH

// Bits per ADC sample.
`define CDR_NADC 8

// Samples per interleaved word. Must be a power of two.
`define CDR_NTI 16

// Interpolator code width.
`define CDR_NPI 9

// Number of interpolator outputs.
`define CDR_NOUT 4

// Fractional bits carried by the phase and frequency estimators.
`define CDR_EST_SHIFT 8

`endif

//--- rtl/cdr_pkg.sv
`default_nettype none

package cdr_pkg;

    `include "cdr_defs.svh"

    // One converter sample.
    typedef logic signed [`CDR_NADC-1:0] adc_word_t;

    // Phase error, detector offset and visible phase estimate.
    typedef logic signed [`CDR_NADC+1:0] pd_err_t;

    // Loop filter state with fractional bits below the visible phase.
    typedef logic signed [`CDR_NADC+1+`CDR_EST_SHIFT:0] est_word_t;

    typedef logic [`CDR_NPI-1:0] pi_code_t;  // Interpolator code.

endpackage

`default_nettype wire

//--- rtl/mm_pd.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdr_defs.svh"

module mm_pd (
    input  wire logic               clk,
    input  wire logic               ext_rstb,
    input  wire cdr_pkg::adc_word_t din_i [`CDR_NTI],  // Index 0 is the earliest.
    input  wire cdr_pkg::pd_err_t   pd_offset_i,
    output logic signed [$bits(cdr_pkg::pd_err_t)-1:0] pd_out_o
);

    import cdr_pkg::*;

    localparam int PD_W     = $bits(pd_err_t);
    localparam int NTI_LOG2 = $clog2(`CDR_NTI);
    localparam int TERM_W   = `CDR_NADC + 2;
    localparam int SUM_W    = TERM_W + NTI_LOG2;

    adc_word_t                 prev_last_q;  // Last sample of the previous word.
    adc_word_t                 prev_s [`CDR_NTI];
    logic signed [TERM_W-1:0]  term [`CDR_NTI];
    logic signed [SUM_W-1:0]   sum;
    logic signed [SUM_W-1:0]   avg;
    logic signed [SUM_W:0]     acc;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            prev_last_q <= '0;
        end else begin
            prev_last_q <= din_i[`CDR_NTI-1];
        end
    end

    assign prev_s[0] = prev_last_q;

    for (genvar k = 1; k < `CDR_NTI; k++) begin : g_prev
        assign prev_s[k] = din_i[k-1];
    end

    // Each Mueller-Muller term is x[k]*sgn(x[k-1]) minus x[k-1]*sgn(x[k]).
    for (genvar k = 0; k < `CDR_NTI; k++) begin : g_term
        logic signed [TERM_W-1:0] cur_x;
        logic signed [TERM_W-1:0] prev_x;
        logic signed [TERM_W-1:0] cur_signed;
        logic signed [TERM_W-1:0] prev_signed;

        assign cur_x  = din_i[k];      // Sign extended before negation.
        assign prev_x = prev_s[k];

        assign cur_signed  = prev_s[k][`CDR_NADC-1] ? -cur_x : cur_x;
        assign prev_signed = din_i[k][`CDR_NADC-1] ? -prev_x : prev_x;

        assign term[k] = cur_signed - prev_signed;
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < `CDR_NTI; k++) begin
            sum = sum + term[k];
        end
    end

    assign avg = sum >>> NTI_LOG2;  // Mean over the word.
    assign acc = avg + pd_offset_i;

    // Clamp to the error range.
    always_comb begin
        if (acc[SUM_W:PD_W-1] == {(SUM_W-PD_W+2){acc[SUM_W]}}) begin
            pd_out_o = acc[PD_W-1:0];
        end else if (acc[SUM_W]) begin
            pd_out_o = {1'b1, {(PD_W-1){1'b0}}};
        end else begin
            pd_out_o = {1'b0, {(PD_W-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

//--- rtl/mm_cdr.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdr_defs.svh"

module mm_cdr #(
    parameter int prop_width = 8,
    parameter int intg_width = 8
) (
    input  wire logic                      clk,
    input  wire logic                      ext_rstb,
    input  wire cdr_pkg::adc_word_t        din_i [`CDR_NTI],
    input  wire cdr_pkg::pd_err_t          pd_offset_i,
    input  wire logic signed [prop_width-1:0] kp_i,
    input  wire logic signed [intg_width-1:0] ki_i,
    input  wire logic                      en_freq_est_i,
    input  wire logic                      en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t         pi_ctl_ext_i,
    output cdr_pkg::pi_code_t              pi_ctl_o [`CDR_NOUT],
    output cdr_pkg::pd_err_t               phase_est_out_o,
    output cdr_pkg::est_word_t             freq_est_update_o
);

    import cdr_pkg::*;

    localparam int EST_W    = $bits(est_word_t);
    localparam int PI_SHIFT = `CDR_NADC + 2 - `CDR_NPI;

    pd_err_t   phase_error;
    est_word_t phase_est_q;
    est_word_t phase_est_d;
    est_word_t freq_est_q;
    est_word_t freq_est_d;
    est_word_t freq_est_update;
    pd_err_t   phase_est_out;
    pi_code_t  scaled_pi_ctl;

    mm_pd u_mm_pd (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (pd_offset_i),
        .pd_out_o    (phase_error)
    );

    // Integral path. Sums wrap modulo the estimator width.
    always_comb begin
        freq_est_update = freq_est_q + ki_i * phase_error;
        freq_est_d      = en_freq_est_i ? freq_est_update : '0;
    end

    // Proportional path plus the previous frequency estimate.
    assign phase_est_d = phase_est_q + kp_i * phase_error + freq_est_q;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_est_q <= '0;
            freq_est_q  <= '0;
        end else begin
            phase_est_q <= phase_est_d;
            freq_est_q  <= freq_est_d;
        end
    end

    // Drop the fractional bits.
    assign phase_est_out = phase_est_q[EST_W-1:`CDR_EST_SHIFT];

    // Top CDR_NPI bits of the visible phase.
    assign scaled_pi_ctl = phase_est_out[PI_SHIFT +: `CDR_NPI];

    for (genvar k = 0; k < `CDR_NOUT; k++) begin : g_pi_out
        assign pi_ctl_o[k] = en_ext_pi_ctl_i ? pi_ctl_ext_i : scaled_pi_ctl;
    end

    assign phase_est_out_o   = phase_est_out;
    assign freq_est_update_o = freq_est_update;  // To the debug sampler.

endmodule

`default_nettype wire

//--- rtl/cdr_debug_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module cdr_debug_sampler (
    input  wire logic               clk,
    input  wire logic               ext_rstb,
    input  wire logic               sample_req_i,
    input  wire cdr_pkg::pd_err_t   phase_est_i,
    input  wire cdr_pkg::est_word_t freq_est_i,
    output cdr_pkg::pd_err_t        phase_est_o,
    output cdr_pkg::est_word_t      freq_est_o
);

    import cdr_pkg::*;

    typedef enum logic [1:0] {
        WAIT,
        READY,
        SAMPLE
    } sampler_state_t;

    sampler_state_t state_q;

    // Request must go low, then high, for each capture.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q     <= WAIT;
            phase_est_o <= '0;
            freq_est_o  <= '0;
        end else begin
            case (state_q)
                WAIT: begin
                    if (!sample_req_i) begin
                        state_q <= READY;
                    end
                end
                READY: begin
                    if (sample_req_i) begin
                        state_q <= SAMPLE;
                    end
                end
                SAMPLE: begin
                    // Both estimates from the same cycle.
                    phase_est_o <= phase_est_i;
                    freq_est_o  <= freq_est_i;
                    state_q     <= WAIT;
                end
                default: state_q <= WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/cdr_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdr_defs.svh"

module cdr_top (
    input  wire logic               clk,
    input  wire logic               ext_rstb,
    input  wire cdr_pkg::adc_word_t din_i [`CDR_NTI],
    input  wire cdr_pkg::pd_err_t   pd_offset_i,
    input  wire logic signed [7:0]  kp_i,
    input  wire logic signed [7:0]  ki_i,
    input  wire logic               en_freq_est_i,
    input  wire logic               en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t  pi_ctl_ext_i,
    input  wire logic               sample_req_i,
    output cdr_pkg::pi_code_t       pi_ctl_o [`CDR_NOUT],
    output cdr_pkg::pd_err_t        phase_est_o,
    output cdr_pkg::est_word_t      freq_est_o
);

    import cdr_pkg::*;

    pd_err_t   phase_est_out;    // Visible phase of the loop.
    est_word_t freq_est_update;

    mm_cdr #(
        .prop_width (8),
        .intg_width (8)
    ) u_mm_cdr (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .din_i             (din_i),
        .pd_offset_i       (pd_offset_i),
        .kp_i              (kp_i),
        .ki_i              (ki_i),
        .en_freq_est_i     (en_freq_est_i),
        .en_ext_pi_ctl_i   (en_ext_pi_ctl_i),
        .pi_ctl_ext_i      (pi_ctl_ext_i),
        .pi_ctl_o          (pi_ctl_o),
        .phase_est_out_o   (phase_est_out),
        .freq_est_update_o (freq_est_update)
    );

    cdr_debug_sampler u_cdr_debug_sampler (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .phase_est_i  (phase_est_out),
        .freq_est_i   (freq_est_update),
        .phase_est_o  (phase_est_o),
        .freq_est_o   (freq_est_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_cdr_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdr_defs.svh"

module tb_cdr_top;

    import cdr_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int OVERRIDE_CYCLES = 40;
    localparam int ON_CYCLES       = 400;
    localparam int OFF_CYCLES      = 200;
    localparam int DEBUG_REQS      = 8;
    localparam int DEBUG_SLOT      = 8;  // Two low cycles plus up to six high.
    localparam int TOTAL_CYCLES    = RESET_CYCLES + OVERRIDE_CYCLES + ON_CYCLES + OFF_CYCLES
                                     + (DEBUG_REQS + 1) * DEBUG_SLOT + 4;

    localparam logic [1:0] S_WAIT   = 2'd0;
    localparam logic [1:0] S_READY  = 2'd1;
    localparam logic [1:0] S_SAMPLE = 2'd2;

    logic             clk;
    logic             ext_rstb;
    adc_word_t        din [`CDR_NTI];
    pd_err_t          pd_offset;
    logic signed [7:0] kp;
    logic signed [7:0] ki;
    logic             en_freq_est;
    logic             en_ext_pi_ctl;
    pi_code_t         pi_ctl_ext;
    logic             sample_req;
    pi_code_t         pi_ctl [`CDR_NOUT];
    pd_err_t          phase_est;
    est_word_t        freq_est;

    string test_name = "reset";
    int    fail_count = 0;

    // Reference model state.
    adc_word_t  model_prev_last;
    est_word_t  model_phase_q;
    est_word_t  model_freq_q;
    logic [1:0] model_state;
    pd_err_t    model_phase_cap;
    est_word_t  model_freq_cap;
    int         model_err;
    est_word_t  model_freq_upd;
    pd_err_t    model_visible;
    pi_code_t   exp_code;
    pi_code_t   exp_pi;

    cdr_top dut_i (
        .clk             (clk),
        .ext_rstb        (ext_rstb),
        .din_i           (din),
        .pd_offset_i     (pd_offset),
        .kp_i            (kp),
        .ki_i            (ki),
        .en_freq_est_i   (en_freq_est),
        .en_ext_pi_ctl_i (en_ext_pi_ctl),
        .pi_ctl_ext_i    (pi_ctl_ext),
        .sample_req_i    (sample_req),
        .pi_ctl_o        (pi_ctl),
        .phase_est_o     (phase_est),
        .freq_est_o      (freq_est)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int sign_of(input int x);
        return (x >= 0) ? 1 : -1;
    endfunction

    // Mean of the Mueller-Muller terms plus offset and clamped to the error range.
    function automatic int phase_error_of(input adc_word_t w [`CDR_NTI],
                                          input adc_word_t prev,
                                          input pd_err_t off);
        int sum;
        int c;
        int p;
        int acc;
        int lim;
        sum = 0;
        for (int k = 0; k < `CDR_NTI; k++) begin
            c = int'(w[k]);
            p = (k == 0) ? int'(prev) : int'(w[k-1]);
            sum += c * sign_of(p) - p * sign_of(c);
        end
        acc = (sum >>> $clog2(`CDR_NTI)) + int'(off);
        lim = 1 << (`CDR_NADC + 1);
        if (acc > lim - 1) acc = lim - 1;
        if (acc < -lim) acc = -lim;
        return acc;
    endfunction

    always_comb begin
        model_err      = phase_error_of(din, model_prev_last, pd_offset);
        model_freq_upd = est_word_t'(int'(model_freq_q) + int'(ki) * model_err);
        model_visible  = pd_err_t'(int'(model_phase_q) >>> `CDR_EST_SHIFT);
        exp_code       = pi_code_t'(int'(model_visible) >>> (`CDR_NADC + 2 - `CDR_NPI));
        exp_pi         = en_ext_pi_ctl ? pi_ctl_ext : exp_code;
    end

    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            model_prev_last <= '0;
            model_phase_q   <= '0;
            model_freq_q    <= '0;
            model_state     <= S_WAIT;
            model_phase_cap <= '0;
            model_freq_cap  <= '0;
        end else begin
            model_prev_last <= din[`CDR_NTI-1];
            model_freq_q    <= en_freq_est ? model_freq_upd : '0;
            model_phase_q   <= est_word_t'(int'(model_phase_q) + int'(kp) * model_err
                                           + int'(model_freq_q));
            case (model_state)
                S_WAIT:  if (!sample_req) model_state <= S_READY;
                S_READY: if (sample_req) model_state <= S_SAMPLE;
                default: begin
                    model_phase_cap <= model_visible;
                    model_freq_cap  <= model_freq_upd;
                    model_state     <= S_WAIT;
                end
            endcase
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        fail_count++;
        $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        $display("Checks failed");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("%s: %s", test_name, msg);
        $display("Checks failed");
        $fatal(1, "Stopped at the first failure.");
    endtask

    for (genvar k = 0; k < `CDR_NOUT; k++) begin : g_pi_check
        a_pi_code: assert property (@(posedge clk) pi_ctl[k] == exp_pi)
            else report_mismatch($sformatf("pi_ctl_o[%0d]", k), int'($sampled(exp_pi)),
                                 int'($sampled(pi_ctl[k])));
    end

    a_reset_phase: assert property (@(posedge clk)
        (!ext_rstb || $rose(ext_rstb)) |-> phase_est == '0)
        else report_mismatch("phase_est_o in reset", 0, int'($sampled(phase_est)));

    a_reset_freq: assert property (@(posedge clk)
        (!ext_rstb || $rose(ext_rstb)) |-> freq_est == '0)
        else report_mismatch("freq_est_o in reset", 0, int'($sampled(freq_est)));

    a_cap_phase: assert property (@(posedge clk) phase_est == model_phase_cap)
        else report_mismatch("phase_est_o", int'($sampled(model_phase_cap)),
                             int'($sampled(phase_est)));

    a_cap_freq: assert property (@(posedge clk) freq_est == model_freq_cap)
        else report_mismatch("freq_est_o", int'($sampled(model_freq_cap)),
                             int'($sampled(freq_est)));

    // Outputs may only move at the edge that leaves SAMPLE.
    a_cap_once: assert property (@(posedge clk) disable iff (!ext_rstb)
        model_state != S_SAMPLE |=> $stable(phase_est) && $stable(freq_est))
        else report_failure("debug outputs changed without a capture");

    a_freq_off: assert property (@(posedge clk) disable iff (!ext_rstb)
        (!en_freq_est && $past(en_freq_est) == 1'b0 && ki == '0 && model_state == S_SAMPLE)
        |=> freq_est == '0)
        else report_mismatch("freq_est_o with integrator off", 0, int'($sampled(freq_est)));

    task automatic new_word();
        for (int k = 0; k < `CDR_NTI; k++) begin
            din[k] = adc_word_t'($urandom);
        end
    endtask

    task automatic advance(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            new_word();
        end
    endtask

    task automatic request_capture(input int hold);
        sample_req = 1'b0;
        advance(2);
        sample_req = 1'b1;
        advance(hold);
    endtask

    // Open loop with gains and offset redrawn every 50 cycles.
    task automatic run_open_loop(input int n);
        for (int i = 0; i < n; i++) begin
            if (i % 50 == 0) begin
                kp        = 8'($urandom);
                ki        = 8'($urandom);
                pd_offset = pd_err_t'($urandom);
            end
            en_ext_pi_ctl = ($urandom % 8) == 0;  // Brief overrides on a running loop.
            pi_ctl_ext    = pi_code_t'($urandom);
            advance(1);
        end
    endtask

    initial begin
        void'($urandom(32'h0892_4699));
        ext_rstb      = 1'b1;
        pd_offset     = '0;
        kp            = '0;
        ki            = '0;
        en_freq_est   = 1'b1;
        en_ext_pi_ctl = 1'b0;
        pi_ctl_ext    = '0;
        sample_req    = 1'b0;
        foreach (din[k]) din[k] = '0;
        #1 ext_rstb = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 ext_rstb = 1'b1;

        test_name     = "override";
        kp            = 8'sd37;
        ki            = 8'sd5;
        en_ext_pi_ctl = 1'b1;
        for (int i = 0; i < OVERRIDE_CYCLES; i++) begin
            pi_ctl_ext = pi_code_t'($urandom);
            advance(1);
        end
        en_ext_pi_ctl = 1'b0;

        test_name = "integrator_on";
        run_open_loop(ON_CYCLES);
        en_ext_pi_ctl = 1'b0;

        test_name   = "integrator_off";
        en_freq_est = 1'b0;
        run_open_loop(OFF_CYCLES);
        en_ext_pi_ctl = 1'b0;
        ki            = '0;
        request_capture(4);

        test_name   = "debug_capture";
        en_freq_est = 1'b1;
        ki          = 8'sd3;
        kp          = -8'sd21;
        for (int r = 0; r < DEBUG_REQS; r++) begin
            request_capture(3 + ($urandom % 4));  // Held high past the capture.
        end

        @(posedge clk);
        #1;
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 8 * 2);
        $display("Watchdog expired: the simulation did not finish in time.");
        $display("Checks failed");
        $fatal(1, "Run hung.");
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
rtl/cdr_pkg.sv
rtl/mm_pd.sv
rtl/mm_cdr.sv
rtl/cdr_debug_sampler.sv
rtl/cdr_top.sv
tests/tb_cdr_top.sv
